// File: arcade_params.svh
`ifndef ARCADE_PARAMS_SVH
`define ARCADE_PARAMS_SVH

// clock enable dividers, in clk_sys cycles
`define ARC_CEN_DIV 8
`define ARC_SND_DIV 45

// loader interface
`define ARC_ADDR_W 25
`define ARC_SPRITE_BASE 65536
`define ARC_ROM_INDEX 0

// variant select
`define ARC_GAME_W 7
`define ARC_GAME_PYRAMID 0
`define ARC_GAME_SPINNER 2
`define ARC_GAME_TWINSTICK 3
`define ARC_GAME_TRACKBALL 7

`endif

// File: arcade_pkg.sv
`include "arcade_params.svh"

package arcade_pkg;

	typedef enum logic [`ARC_GAME_W-1:0] {
		GAME_PYRAMID   = `ARC_GAME_PYRAMID,
		GAME_SPINNER   = `ARC_GAME_SPINNER,
		GAME_TWINSTICK = `ARC_GAME_TWINSTICK,
		GAME_TRACKBALL = `ARC_GAME_TRACKBALL
	} game_e;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic up_b; // second stick
		logic down_b;
		logic left_b;
		logic right_b;
	} player_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} panel_t;

	typedef struct packed {
		logic        addr; // 0 status, 1 game code
		logic [31:0] data;
	} cfg_wr_t;

	typedef struct packed {
		logic        reset_req;
		logic        service;
		logic        diagonal;
		logic [7:0]  dip;
		game_e       game;
	} cfg_t;

	typedef struct packed {
		logic cpu_clk;
		logic cen_5;
		logic cen_10_p;
		logic cen_10_n;
		logic snd_cen;
	} cen_t;

	typedef struct packed {
		logic [7:0] angle_hi;
		logic [7:0] angle_lo;
	} spin_view_t;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
	} track_view_t;

	// one analog port word, read as spinner or trackball
	typedef union packed {
		spin_view_t  spin;
		track_view_t track;
	} analog_u;

	typedef struct packed {
		logic        region; // 0 main, 1 sprite
		logic [22:0] waddr;
		logic        lane; // 0 low byte
		logic [7:0]  data;
	} rom_wr_t;

	typedef struct packed {
		logic                   active;
		logic [7:0]             index;
		logic                   wr;
		logic [`ARC_ADDR_W-1:0] addr;
		logic [7:0]             data;
	} dl_t;

endpackage

// File: cfg_regs.sv
`include "arcade_params.svh"

module cfg_regs (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic                 cfg_we_i,
	input  arcade_pkg::cfg_wr_t  cfg_wr_i,
	output arcade_pkg::cfg_t     cfg_o
);

	logic [31:0]            status_q;
	logic [`ARC_GAME_W-1:0] game_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			status_q <= '0;
			game_q   <= '0;
		end else if (cfg_we_i) begin
			if (cfg_wr_i.addr) begin
				game_q <= cfg_wr_i.data[`ARC_GAME_W-1:0];
			end else begin
				status_q <= cfg_wr_i.data;
			end
		end
	end

	// only the bits the front end acts on
	always_comb begin
		cfg_o.reset_req = status_q[0];
		cfg_o.service   = status_q[8];
		cfg_o.diagonal  = status_q[9];
		cfg_o.dip       = status_q[23:16];
		cfg_o.game      = arcade_pkg::game_e'(game_q); // unknown codes fall to pyramid
	end

endmodule

// File: clk_enables.sv
`include "arcade_params.svh"

module clk_enables (
	input  logic              clk_sys,
	input  logic              rst_n_i,
	output arcade_pkg::cen_t  cen_o
);

	localparam int CPU_W = $clog2(`ARC_CEN_DIV);
	localparam int SND_W = $clog2(`ARC_SND_DIV);

	logic [CPU_W-1:0] cpu_cnt;
	logic [SND_W-1:0] snd_cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			cpu_cnt <= '0;
			snd_cnt <= '0;
			cen_o   <= '0;
		end else begin
			cpu_cnt <= (cpu_cnt == CPU_W'(`ARC_CEN_DIV - 1)) ? '0 : cpu_cnt + 1'b1;

			cen_o.cpu_clk  <= cpu_cnt[2]; // 50% duty cpu clock
			cen_o.cen_5    <= cpu_cnt == 3'd7;
			cen_o.cen_10_p <= cpu_cnt == 3'd3 || cpu_cnt == 3'd7;
			cen_o.cen_10_n <= cpu_cnt == 3'd1 || cpu_cnt == 3'd5;

			if (snd_cnt == SND_W'(`ARC_SND_DIV - 1)) begin
				snd_cnt       <= '0;
				cen_o.snd_cen <= 1'b1;
			end else begin
				snd_cnt       <= snd_cnt + 1'b1;
				cen_o.snd_cen <= 1'b0;
			end
		end
	end

endmodule

// File: spinner.sv
module spinner (
	input  logic       clk_sys,
	input  logic       rst_n_i,
	input  logic       clear_i,
	input  logic       vblank_i,
	input  logic       dec_i,
	input  logic       inc_i,
	output logic [7:0] pos_o
);

	logic vblank_q;
	logic vb_rise;

	assign vb_rise = vblank_i & ~vblank_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			vblank_q <= 1'b0;
		end else begin
			vblank_q <= vblank_i;
		end
	end

	// one step per frame, both buttons cancel out
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i || clear_i) begin
			pos_o <= '0;
		end else if (vb_rise) begin
			case ({inc_i, dec_i})
				2'b10: pos_o <= pos_o + 8'd1;
				2'b01: pos_o <= pos_o - 8'd1; // wraps to 255
				default: pos_o <= pos_o;
			endcase
		end
	end

endmodule

// File: input_mapper.sv
module input_mapper (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  arcade_pkg::cfg_t     cfg_i,
	input  arcade_pkg::player_t  player1_i,
	input  arcade_pkg::player_t  player2_i,
	input  arcade_pkg::panel_t   panel_i,
	input  logic                 vblank_i,
	input  logic                 spin_clear_i,
	output logic [7:0]           in1_o,
	output logic [7:0]           in4_o,
	output arcade_pkg::analog_u  analog_o
);

	logic [7:0]          spin_pos;
	logic [7:0]          track_x;
	logic [7:0]          track_y;
	logic [7:0]          in1_d;
	logic [7:0]          in4_d;
	arcade_pkg::analog_u analog_d;

	// dial on the fire_c/d buttons or the second stick
	spinner i_spin (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.clear_i  (spin_clear_i),
		.vblank_i (vblank_i),
		.dec_i    (player1_i.fire_c | player1_i.left_b),
		.inc_i    (player1_i.fire_d | player1_i.right_b),
		.pos_o    (spin_pos)
	);

	spinner i_track_x (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.clear_i  (spin_clear_i),
		.vblank_i (vblank_i),
		.dec_i    (player1_i.left),
		.inc_i    (player1_i.right),
		.pos_o    (track_x)
	);

	spinner i_track_y (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.clear_i  (spin_clear_i),
		.vblank_i (vblank_i),
		.dec_i    (player1_i.up),
		.inc_i    (player1_i.down),
		.pos_o    (track_y)
	);

	// down, up, left, right nibble; diagonal mode rotates to corner pairs
	function automatic logic [3:0] dir_bits(arcade_pkg::player_t p, logic diag);
		logic [3:0] d;
		if (diag) begin
			d = {p.down & p.left, p.up & p.right, p.left & p.up, p.right & p.down};
		end else begin
			d = {p.down, p.up, p.left, p.right};
		end
		return d;
	endfunction

	always_comb begin
		in1_d    = {player1_i.fire_a, ~cfg_i.service, 2'b00,
		            panel_i.coin2, panel_i.coin1, panel_i.start2, panel_i.start1};
		in4_d    = {dir_bits(player2_i, cfg_i.diagonal), dir_bits(player1_i, cfg_i.diagonal)};
		analog_d = '0;

		case (cfg_i.game)
			arcade_pkg::GAME_SPINNER: begin
				in1_d = {~cfg_i.service, player1_i.fire_a, 4'd0, panel_i.coin2, panel_i.coin1};
				in4_d = {player1_i.fire_b, panel_i.start2, panel_i.start1, player1_i.fire_a,
				         player1_i.left, player1_i.down, player1_i.right, player1_i.up};
				analog_d.spin.angle_hi = spin_pos;
				analog_d.spin.angle_lo = spin_pos;
			end
			arcade_pkg::GAME_TWINSTICK: begin
				in1_d = {panel_i.start2, panel_i.start1, 2'b00,
				         panel_i.coin2, panel_i.coin1, player1_i.fire_a, ~cfg_i.service};
				in4_d = {player1_i.left, player1_i.down, player1_i.right, player1_i.up,
				         player2_i.left | player1_i.left_b,   // right stick
				         player2_i.down | player1_i.down_b,
				         player2_i.right | player1_i.right_b,
				         player2_i.up | player1_i.up_b};
			end
			arcade_pkg::GAME_TRACKBALL: begin
				in1_d = {4'd0, panel_i.coin2, panel_i.coin1, player1_i.fire_a, ~cfg_i.service};
				in4_d = {4'd0, player2_i.fire_a, player2_i.fire_b,
				         player1_i.fire_a, player1_i.fire_b};
				analog_d.track.x = track_x;
				analog_d.track.y = track_y;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			in1_o    <= '0;
			in4_o    <= '0;
			analog_o <= '0;
		end else begin
			in1_o    <= in1_d;
			in4_o    <= in4_d;
			analog_o <= analog_d;
		end
	end

endmodule

// File: download_ctrl.sv
`include "arcade_params.svh"

module download_ctrl (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  arcade_pkg::cfg_t     cfg_i,
	input  arcade_pkg::dl_t      dl_i,
	output logic                 rom_req_o,
	input  logic                 rom_ack_i,
	output arcade_pkg::rom_wr_t  rom_wr_o,
	output logic                 core_reset_o
);

	logic                   wr_q;
	logic                   active_q;
	logic                   ack_wait_q;
	logic                   rom_loaded;
	logic                   rom_sel;
	logic                   accept;
	logic [`ARC_ADDR_W-1:0] spr_off;
	arcade_pkg::rom_wr_t    rom_wr_d;

	assign rom_sel = dl_i.active && (dl_i.index == 8'(`ARC_ROM_INDEX));
	// edges during an open transfer are dropped
	assign accept  = rom_sel && dl_i.wr && !wr_q && !rom_req_o && !ack_wait_q && !rom_ack_i;
	assign spr_off = dl_i.addr - `ARC_ADDR_W'(`ARC_SPRITE_BASE);

	always_comb begin
		rom_wr_d.data = dl_i.data;
		if (dl_i.addr < `ARC_ADDR_W'(`ARC_SPRITE_BASE)) begin
			rom_wr_d.region = 1'b0;
			rom_wr_d.waddr  = dl_i.addr[23:1];
			rom_wr_d.lane   = dl_i.addr[0];
		end else begin
			rom_wr_d.region = 1'b1;
			rom_wr_d.waddr  = {8'd0, spr_off[13:0], spr_off[15]}; // two roms side by side
			rom_wr_d.lane   = spr_off[14];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			rom_wr_o <= rom_wr_d;
		end
	end

	// four-phase req/ack
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			wr_q       <= 1'b0;
			rom_req_o  <= 1'b0;
			ack_wait_q <= 1'b0;
		end else begin
			wr_q <= dl_i.wr;
			if (accept) begin
				rom_req_o <= 1'b1;
			end else if (rom_req_o && rom_ack_i) begin
				rom_req_o  <= 1'b0;
				ack_wait_q <= 1'b1; // until ack drops
			end else if (ack_wait_q && !rom_ack_i) begin
				ack_wait_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			active_q     <= 1'b0;
			rom_loaded   <= 1'b0;
			core_reset_o <= 1'b1;
		end else begin
			active_q <= dl_i.active;
			if (active_q && !dl_i.active) begin
				rom_loaded <= 1'b1;
			end
			core_reset_o <= cfg_i.reset_req | ~rom_loaded;
		end
	end

endmodule

// File: arcade_io_top.sv
module arcade_io_top (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic                 cfg_we_i,
	input  arcade_pkg::cfg_wr_t  cfg_wr_i,
	input  arcade_pkg::player_t  player1_i,
	input  arcade_pkg::player_t  player2_i,
	input  arcade_pkg::panel_t   panel_i,
	input  logic                 vblank_i,
	input  logic                 spin_clear_i,
	input  arcade_pkg::dl_t      dl_i,
	input  logic                 rom_ack_i,
	output logic [7:0]           in1_o,
	output logic [7:0]           in4_o,
	output arcade_pkg::analog_u  analog_o,
	output arcade_pkg::cen_t     cen_o,
	output logic                 rom_req_o,
	output arcade_pkg::rom_wr_t  rom_wr_o,
	output logic                 core_reset_o,
	output logic [7:0]           dip_o
);

	arcade_pkg::cfg_t cfg;

	assign dip_o = cfg.dip; // straight to the board dip inputs

	cfg_regs i_cfg_regs (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.cfg_we_i (cfg_we_i),
		.cfg_wr_i (cfg_wr_i),
		.cfg_o    (cfg)
	);

	clk_enables i_clk_enables (
		.clk_sys (clk_sys),
		.rst_n_i (rst_n_i),
		.cen_o   (cen_o)
	);

	input_mapper i_input_mapper (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.cfg_i        (cfg),
		.player1_i    (player1_i),
		.player2_i    (player2_i),
		.panel_i      (panel_i),
		.vblank_i     (vblank_i),
		.spin_clear_i (spin_clear_i),
		.in1_o        (in1_o),
		.in4_o        (in4_o),
		.analog_o     (analog_o)
	);

	download_ctrl i_download_ctrl (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.cfg_i        (cfg),
		.dl_i         (dl_i),
		.rom_req_o    (rom_req_o),
		.rom_ack_i    (rom_ack_i),
		.rom_wr_o     (rom_wr_o),
		.core_reset_o (core_reset_o)
	);

endmodule

// File: arcade_props.sv
module arcade_props (
	input logic                 clk_sys,
	input logic                 rst_n_i,
	input logic                 rom_req_o,
	input logic                 rom_ack_i,
	input arcade_pkg::rom_wr_t  rom_wr_o,
	input arcade_pkg::cen_t     cen_o
);

	int fail_cnt = 0;

	wr_stable: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rom_req_o |=> !rom_req_o || $stable(rom_wr_o))
		else begin
			fail_cnt++;
			$error("rom_wr_o changed while rom_req_o was high");
		end

	no_req_on_ack: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		$rose(rom_req_o) |-> !$past(rom_ack_i))
		else begin
			fail_cnt++;
			$error("rom_req_o rose while rom_ack_i was high");
		end

	// seven quiet cycles before every cen_5
	cen5_gap: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		cen_o.cen_5 |-> !($past(cen_o.cen_5, 1) || $past(cen_o.cen_5, 2) ||
			$past(cen_o.cen_5, 3) || $past(cen_o.cen_5, 4) || $past(cen_o.cen_5, 5) ||
			$past(cen_o.cen_5, 6) || $past(cen_o.cen_5, 7)))
		else begin
			fail_cnt++;
			$error("cen_5 pulses closer than 8 cycles");
		end

	// cen_10_n leads each cen_10_p by two cycles
	cen10_excl: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		cen_o.cen_10_p |-> !cen_o.cen_10_n && $past(cen_o.cen_10_n, 2))
		else begin
			fail_cnt++;
			$error("cen_10_p and cen_10_n out of phase or high together");
		end

endmodule

bind arcade_io_top arcade_props i_props (
	.clk_sys   (clk_sys),
	.rst_n_i   (rst_n_i),
	.rom_req_o (rom_req_o),
	.rom_ack_i (rom_ack_i),
	.rom_wr_o  (rom_wr_o),
	.cen_o     (cen_o)
);

// File: tb_arcade_io.sv
`include "arcade_params.svh"

module tb_arcade_io;

	localparam int TIMEOUT_CYCLES = 20000;

	logic                clk_sys = 1'b0;
	logic                rst_n_i = 1'b0;
	logic                cfg_we_i = 1'b0;
	logic                vblank_i = 1'b0;
	logic                spin_clear_i = 1'b0;
	logic                rom_ack_i = 1'b0;
	arcade_pkg::cfg_wr_t cfg_wr_i = '0;
	arcade_pkg::player_t player1_i = '0;
	arcade_pkg::player_t player2_i = '0;
	arcade_pkg::panel_t  panel_i = '0;
	arcade_pkg::dl_t     dl_i = '0;
	logic [7:0]          in1_o, in4_o, dip_o;
	arcade_pkg::analog_u analog_o;
	arcade_pkg::cen_t    cen_o;
	logic                rom_req_o, core_reset_o;
	arcade_pkg::rom_wr_t rom_wr_o, exp_wr;
	arcade_pkg::rom_wr_t exp_q[$];
	logic                req_q = 1'b0;
	logic [31:0]         rng = 32'd93036;
	logic [31:0]         ack_rng = ~32'd93036; // responder stream
	logic [2:0]          ack_delay = 3'd2;
	logic [7:0]          exp_in1, exp_in4, exp_a, exp_b;
	int                  errors = 0, checks = 0, tests = 0, test_err = 0;
	int                  cycles = 0, xfers = 0;
	int                  chk_mode = 0; // 1 ports, 2 spinner view, 3 trackball view

	always #50 clk_sys = ~clk_sys;

	arcade_io_top i_arcade_io_top (.*);

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// down, up, left, right; corner pairs in diagonal mode
	function automatic logic [3:0] stick_bits(arcade_pkg::player_t p, logic diag);
		if (diag)
			return {p.down && p.left, p.up && p.right, p.left && p.up, p.right && p.down};
		return {p.down, p.up, p.left, p.right};
	endfunction

	// {in1, in4}
	function automatic logic [15:0] ref_ports(int code, logic diag, logic svc,
			arcade_pkg::player_t a, arcade_pkg::player_t b, arcade_pkg::panel_t k);
		case (code)
			`ARC_GAME_SPINNER:
				return {!svc, a.fire_a, 4'd0, k.coin2, k.coin1,
					a.fire_b, k.start2, k.start1, a.fire_a, a.left, a.down, a.right, a.up};
			`ARC_GAME_TWINSTICK:
				return {k.start2, k.start1, 2'd0, k.coin2, k.coin1, a.fire_a, !svc,
					a.left, a.down, a.right, a.up, b.left || a.left_b, b.down || a.down_b,
					b.right || a.right_b, b.up || a.up_b};
			`ARC_GAME_TRACKBALL:
				return {4'd0, k.coin2, k.coin1, a.fire_a, !svc,
					4'd0, b.fire_a, b.fire_b, a.fire_a, a.fire_b};
			default:
				return {a.fire_a, !svc, 2'd0, k.coin2, k.coin1, k.start2, k.start1,
					stick_bits(b, diag), stick_bits(a, diag)};
		endcase
	endfunction

	function automatic arcade_pkg::rom_wr_t ref_rom(logic [24:0] addr, logic [7:0] data);
		arcade_pkg::rom_wr_t w;
		logic [24:0]         off;
		off = addr - 25'(`ARC_SPRITE_BASE);
		w.data = data;
		w.region = addr >= 25'(`ARC_SPRITE_BASE);
		w.waddr = w.region ? 23'({off[13:0], off[15]}) : addr[23:1];
		w.lane = w.region ? off[14] : addr[0];
		return w;
	endfunction

	task automatic report_mismatch(string msg);
		errors++;
		$display("Mismatch at time %0t: %s", $time, msg);
	endtask

	task automatic report_failure(string msg);
		errors++;
		$display("Failure at time %0t: %s", $time, msg);
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("test %0d %s done, %0d errors", tests, name, errors - test_err);
		test_err = errors;
	endtask

	task automatic write_cfg(logic addr, logic [31:0] data);
		@(posedge clk_sys);
		cfg_we_i <= 1'b1;
		cfg_wr_i <= {addr, data};
		@(posedge clk_sys);
		cfg_we_i <= 1'b0;
	endtask

	task automatic pulse_vblank(arcade_pkg::player_t p);
		@(posedge clk_sys);
		player1_i <= p;
		vblank_i  <= 1'b1;
		@(posedge clk_sys);
		vblank_i <= 1'b0;
		@(posedge clk_sys); // counter moved, analog port one cycle behind
	endtask

	task automatic clear_spinners(int mode);
		@(posedge clk_sys);
		spin_clear_i <= 1'b1;
		@(posedge clk_sys);
		spin_clear_i <= 1'b0;
		@(posedge clk_sys);
		exp_a = 8'd0;
		exp_b = 8'd0;
		chk_mode = mode;
	endtask

	task automatic write_byte(logic [7:0] idx, logic [24:0] addr, logic [7:0] data);
		@(posedge clk_sys);
		dl_i.index <= idx;
		dl_i.addr  <= addr;
		dl_i.data  <= data;
		dl_i.wr    <= 1'b1;
		@(posedge clk_sys);
		dl_i.wr <= 1'b0;
	endtask

	// rom side: ack after a random delay, drop it once req falls
	always @(posedge clk_sys) begin
		if (rom_req_o && !rom_ack_i) begin
			if (ack_delay == 3'd0)
				rom_ack_i <= 1'b1;
			else
				ack_delay <= ack_delay - 3'd1;
		end else if (rom_ack_i && !rom_req_o) begin
			rom_ack_i <= 1'b0;
			ack_rng = xorshift(ack_rng);
			ack_delay <= ack_rng[2:0];
			xfers <= xfers + 1;
		end
	end

	always @(negedge clk_sys) begin
		if (chk_mode == 1 && {in1_o, in4_o} !== {exp_in1, exp_in4})
			report_mismatch($sformatf("in1/in4 %h/%h, expected %h/%h",
				in1_o, in4_o, exp_in1, exp_in4));
		if (chk_mode == 2 && analog_o.spin !== {exp_a, exp_a})
			report_mismatch($sformatf("spinner word %h, expected %h twice", analog_o, exp_a));
		if (chk_mode == 3 && analog_o.track !== {exp_a, exp_b})
			report_mismatch($sformatf("trackball x/y %h/%h, expected %h/%h",
				analog_o.track.x, analog_o.track.y, exp_a, exp_b));
		if (chk_mode != 0)
			checks++;
		chk_mode = 0;
		if (dl_i.active && !core_reset_o)
			report_failure("core reset went low while the download was still active");
		if (rom_req_o && !req_q) begin
			checks++;
			if (exp_q.size() == 0) begin
				report_failure("ROM request with no accepted write behind it");
			end else begin
				exp_wr = exp_q.pop_front();
				if (rom_wr_o !== exp_wr)
					report_mismatch($sformatf("rom_wr_o %h, expected %h", rom_wr_o, exp_wr));
			end
		end
		req_q = rom_req_o;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		arcade_pkg::player_t p, q;
		arcade_pkg::panel_t  k;
		logic [24:0]         addr;
		logic [7:0]          dip;
		logic                diag, svc;
		int                  i, g, n, n5, n10p, n10n, nsnd, last5, lastsnd;
		int                  codes[6];
		repeat (5) @(posedge clk_sys);
		rst_n_i <= 1'b1;

		@(negedge clk_sys);
		checks++;
		if (rom_req_o !== 1'b0 || core_reset_o !== 1'b1)
			report_mismatch($sformatf("req %b core_reset %b after reset", rom_req_o, core_reset_o));
		n5 = 0;
		n10p = 0;
		n10n = 0;
		nsnd = 0;
		last5 = -1;
		lastsnd = -1;
		for (i = 0; i < 360; i++) begin
			@(negedge clk_sys);
			if (cen_o.cen_5 && last5 >= 0 && i - last5 != 8)
				report_mismatch($sformatf("cen_5 after %0d cycles, expected 8", i - last5));
			if (cen_o.snd_cen && lastsnd >= 0 && i - lastsnd != 45)
				report_mismatch($sformatf("snd_cen after %0d cycles, expected 45", i - lastsnd));
			// cpu counter was 7 plus the cycles since cen_5
			if (last5 >= 0 && cen_o.cpu_clk !== (((i - last5 + 7) % 8) >= 4))
				report_mismatch($sformatf("cpu_clk %b at %0d cycles after cen_5",
					cen_o.cpu_clk, i - last5));
			if (cen_o.cen_5)
				last5 = i;
			if (cen_o.snd_cen)
				lastsnd = i;
			n5 += cen_o.cen_5;
			n10p += cen_o.cen_10_p;
			n10n += cen_o.cen_10_n;
			nsnd += cen_o.snd_cen;
		end
		checks++;
		if ({n5, n10p, n10n, nsnd} != {32'd45, 32'd90, 32'd90, 32'd8})
			report_mismatch($sformatf("enable counts %0d/%0d/%0d/%0d, expected 45/90/90/8",
				n5, n10p, n10n, nsnd));
		finish_test("enables and reset state");

		// code 5 is unassigned and maps like pyramid
		codes = '{`ARC_GAME_PYRAMID, `ARC_GAME_PYRAMID, `ARC_GAME_SPINNER,
			`ARC_GAME_TWINSTICK, `ARC_GAME_TRACKBALL, 5};
		for (g = 0; g < 6; g++) begin
			rng = xorshift(rng);
			diag = g == 1;
			svc = rng[0];
			dip = rng[15:8];
			write_cfg(1'b1, 32'(codes[g]));
			write_cfg(1'b0, {8'd0, dip, 6'd0, diag, svc, 8'd0});
			for (i = 0; i < 50; i++) begin
				rng = xorshift(rng);
				p = rng[11:0];
				q = rng[23:12];
				k = rng[27:24];
				@(posedge clk_sys);
				player1_i <= p;
				player2_i <= q;
				panel_i   <= k;
				@(posedge clk_sys);
				{exp_in1, exp_in4} = ref_ports(codes[g], diag, svc, p, q, k);
				chk_mode = 1;
			end
			@(negedge clk_sys);
			checks++;
			if (dip_o !== dip)
				report_mismatch($sformatf("dip_o %h, expected %h", dip_o, dip));
		end
		finish_test("input mapping");

		write_cfg(1'b1, `ARC_GAME_SPINNER);
		clear_spinners(2);
		for (i = 0; i < 16; i++) begin
			p = '0;
			p.right_b = i < 5 || i >= 13; // up 5, down 8, then both held
			p.left_b = i >= 5;
			pulse_vblank(p);
			if (i < 13)
				exp_a = (i < 5) ? exp_a + 8'd1 : exp_a - 8'd1;
			chk_mode = 2;
		end
		clear_spinners(2);
		finish_test("spinner");

		write_cfg(1'b1, `ARC_GAME_TRACKBALL);
		clear_spinners(3);
		for (i = 0; i < 30; i++) begin
			rng = xorshift(rng);
			p = '0;
			{p.up, p.down, p.left, p.right} = (i < 3) ? 4'b1010 : rng[3:0];
			pulse_vblank(p);
			exp_a = exp_a + 8'(p.right && !p.left) - 8'(p.left && !p.right);
			exp_b = exp_b + 8'(p.down && !p.up) - 8'(p.up && !p.down);
			chk_mode = 3;
			repeat (rng[5:4]) @(posedge clk_sys);
		end
		finish_test("trackball");

		@(posedge clk_sys);
		dl_i.active <= 1'b1;
		for (i = 0; i < 40; i++) begin
			rng = xorshift(rng);
			addr = rng[28] ? 25'(`ARC_SPRITE_BASE) + 25'(rng[15:0]) : 25'(rng[15:0]);
			if (rng[31:30] == 2'd0) begin
				write_byte(8'd1 + 8'(rng[26:24]), addr, rng[23:16]); // not the rom image
				repeat (6) @(posedge clk_sys);
			end
			exp_q.push_back(ref_rom(addr, rng[23:16]));
			n = xfers;
			write_byte(`ARC_ROM_INDEX, addr, rng[23:16]);
			while (xfers == n)
				@(posedge clk_sys);
			repeat (1 + rng[27:26]) @(posedge clk_sys);
		end
		checks++;
		if (exp_q.size() != 0)
			report_failure($sformatf("%0d accepted writes never made a request", exp_q.size()));
		finish_test("rom download");

		@(posedge clk_sys);
		dl_i.active <= 1'b0;
		n = 0;
		while (core_reset_o && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		checks++;
		if (core_reset_o)
			report_failure("core reset did not fall after the download ended");
		write_cfg(1'b0, 32'd1);
		repeat (2) @(negedge clk_sys);
		checks++;
		if (core_reset_o !== 1'b1)
			report_mismatch("core_reset_o low with status bit 0 set");
		write_cfg(1'b0, 32'd0);
		repeat (2) @(negedge clk_sys);
		checks++;
		if (core_reset_o !== 1'b0)
			report_mismatch("core_reset_o high after status bit 0 cleared");
		finish_test("core reset");

		errors += i_arcade_io_top.i_props.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
arcade_pkg.sv
cfg_regs.sv
clk_enables.sv
spinner.sv
input_mapper.sv
download_ctrl.sv
arcade_io_top.sv
arcade_props.sv
tb_arcade_io.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -Wno-fatal -f sim.f --top-module tb_arcade_io -o tb_arcade_io \
	> build.log 2>&1; then
	echo "verilator build failed, see build.log"
	exit 1
fi

if ! ./obj_dir/tb_arcade_io > sim.log 2>&1; then
	echo "simulation exited with an error status, see sim.log"
	exit 1
fi

if grep -qx "All tests passed" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1
